// ==== common/flop_mem_cfg.svh ====
`ifndef FLOP_MEM_CFG_SVH
`define FLOP_MEM_CFG_SVH

// data bits per word
`define FM_WIDTH 8

// address bits and word count
`define FM_BITADDR 5
`define FM_DEPTH 32

// port counts
`define FM_NUMRPRT 2
`define FM_NUMWPRT 2

// cycles from read to rd_vld
`define FM_RDDLY 3

// mux level followed by the middle register of the read tree
`define FM_MIDSTAGE 2

`endif

// ==== common/flop_mem_pkg.sv ====
`default_nettype none

`include "flop_mem_cfg.svh"

package flop_mem_pkg;

  // one memory word or bit write mask
  typedef logic [`FM_WIDTH-1:0] data_t;

  typedef logic [`FM_BITADDR-1:0] addr_t;

  // one strobe bit per port
  typedef logic [`FM_NUMRPRT-1:0] rport_t;
  typedef logic [`FM_NUMWPRT-1:0] wport_t;

endpackage

`default_nettype wire

// ==== design/wr_input_stage.sv ====
`default_nettype none

`include "flop_mem_cfg.svh"

module wr_input_stage (
  input  wire                       rdclk,
  input  wire                       rst,
  input  wire flop_mem_pkg::wport_t write,
  input  wire flop_mem_pkg::addr_t  wr_adr   [`FM_NUMWPRT],
  input  wire flop_mem_pkg::data_t  din      [`FM_NUMWPRT],
  input  wire flop_mem_pkg::data_t  bw       [`FM_NUMWPRT],
  output flop_mem_pkg::wport_t      write_q,
  output flop_mem_pkg::addr_t       wr_adr_q [`FM_NUMWPRT],
  output flop_mem_pkg::data_t       din_q    [`FM_NUMWPRT],
  output flop_mem_pkg::data_t       bw_q     [`FM_NUMWPRT]
);

  import flop_mem_pkg::*;

  localparam addr_t ADR_MAX = addr_t'(`FM_DEPTH - 1); // last word in the array

  // write strobes
  always_ff @(posedge rdclk) begin
    if (rst) begin
      write_q <= '0;
    end else begin
      write_q <= write;
    end
  end

  always_ff @(posedge rdclk) begin
    for (int p = 0; p < `FM_NUMWPRT; p++) begin
      wr_adr_q[p] <= wr_adr[p];
      din_q[p]    <= din[p];
      bw_q[p]     <= bw[p]; // mask bit 1 = write this bit
    end
  end

  // a strobed write needs a known address inside the array
  for (genvar p = 0; p < `FM_NUMWPRT; p++) begin : g_chk
    a_wr_adr_range: assert property (
      @(posedge rdclk) disable iff (rst)
      write[p] |-> (!$isunknown(wr_adr[p]) && (wr_adr[p] <= ADR_MAX))
    );
  end

endmodule

`default_nettype wire

// ==== flop_mem_array/flop_mem_array.sv ====
`default_nettype none

`include "flop_mem_cfg.svh"

module flop_mem_array (
  input  wire                       rdclk,
  input  wire                       rst,
  input  wire flop_mem_pkg::wport_t write_q,
  input  wire flop_mem_pkg::addr_t  wr_adr_q  [`FM_NUMWPRT],
  input  wire flop_mem_pkg::data_t  din_q     [`FM_NUMWPRT],
  input  wire flop_mem_pkg::data_t  bw_q      [`FM_NUMWPRT],
  output flop_mem_pkg::data_t       mem_words [`FM_DEPTH],
  output logic [`FM_DEPTH*`FM_WIDTH-1:0] fout
);

  import flop_mem_pkg::*;

  localparam int TOP_PRT = `FM_NUMWPRT - 1;

  data_t mem     [`FM_DEPTH];
  data_t mem_nxt [`FM_DEPTH];

  // merge all ports into each word in port order
  // so the highest enabled port decides every shared bit
  always_comb begin
    for (int a = 0; a < `FM_DEPTH; a++) begin
      mem_nxt[a] = mem[a];
      for (int p = 0; p < `FM_NUMWPRT; p++) begin
        if (write_q[p] && (wr_adr_q[p] == addr_t'(a))) begin
          mem_nxt[a] = (mem_nxt[a] & ~bw_q[p]) | (din_q[p] & bw_q[p]);
        end
      end
    end
  end

  always_ff @(posedge rdclk) begin
    if (rst) begin
      for (int a = 0; a < `FM_DEPTH; a++) begin
        mem[a] <= '0;
      end
    end else begin
      for (int a = 0; a < `FM_DEPTH; a++) begin
        mem[a] <= mem_nxt[a];
      end
    end
  end

  // read tap and flat view straight off the flops
  always_comb begin
    for (int a = 0; a < `FM_DEPTH; a++) begin
      mem_words[a] = mem[a];
      fout[a*`FM_WIDTH +: `FM_WIDTH] = mem[a]; // word 0 in the low bits
    end
  end

  // the top port never loses a masked bit
  a_top_port_wins: assert property (
    @(posedge rdclk) disable iff (rst)
    write_q[TOP_PRT] |=>
      ((mem[$past(wr_adr_q[TOP_PRT])] & $past(bw_q[TOP_PRT])) ==
       ($past(din_q[TOP_PRT]) & $past(bw_q[TOP_PRT])))
  );

endmodule

`default_nettype wire

// ==== read_mux_tree/read_mux_tree.sv ====
`default_nettype none

`include "flop_mem_cfg.svh"

module read_mux_tree (
  input  wire                       rdclk,
  input  wire                       rst,
  input  wire flop_mem_pkg::rport_t read,
  input  wire flop_mem_pkg::addr_t  rd_adr    [`FM_NUMRPRT],
  input  wire flop_mem_pkg::data_t  mem_words [`FM_DEPTH],
  output flop_mem_pkg::data_t       rd_dout   [`FM_NUMRPRT],
  output flop_mem_pkg::rport_t      rd_vld
);

  import flop_mem_pkg::*;

  localparam int MID_N   = `FM_DEPTH >> `FM_MIDSTAGE; // words left at the middle register
  localparam int UP_BITS = `FM_BITADDR - `FM_MIDSTAGE; // address bits still to apply

  addr_t  rd_adr_q [`FM_NUMRPRT];
  rport_t vld_sr   [`FM_RDDLY];
  wire data_t tree_out [`FM_NUMRPRT];

  always_ff @(posedge rdclk) begin
    for (int p = 0; p < `FM_NUMRPRT; p++) begin
      rd_adr_q[p] <= rd_adr[p];
    end
  end

  // trees in heap order with children 2n and 2n+1 under node n
  // so level and steering bit of a node follow from clog2(n+1)
  for (genvar p = 0; p < `FM_NUMRPRT; p++) begin : g_port
    wire data_t         lo_node [MID_N : 2*`FM_DEPTH-1];
    wire data_t         hi_node [1 : 2*MID_N-1];
    data_t              mid_q   [MID_N];
    logic [UP_BITS-1:0] adr_mid_q;

    for (genvar n = 0; n < `FM_DEPTH; n++) begin : g_leaf
      assign lo_node[`FM_DEPTH+n] = mem_words[n];
    end

    // levels 1 to FM_MIDSTAGE from address bit 0 up
    for (genvar n = MID_N; n < `FM_DEPTH; n++) begin : g_lo
      localparam int SEL = `FM_BITADDR - $clog2(n + 1);
      assign lo_node[n] = rd_adr_q[p][SEL] ? lo_node[2*n+1] : lo_node[2*n];
    end

    always_ff @(posedge rdclk) begin
      for (int n = 0; n < MID_N; n++) begin
        mid_q[n] <= lo_node[MID_N+n];
      end
      adr_mid_q <= rd_adr_q[p][`FM_BITADDR-1:`FM_MIDSTAGE]; // bits the upper levels need
    end

    for (genvar n = 0; n < MID_N; n++) begin : g_mid
      assign hi_node[MID_N+n] = mid_q[n];
    end

    // remaining levels up to the root
    for (genvar n = 1; n < MID_N; n++) begin : g_hi
      localparam int SEL = UP_BITS - $clog2(n + 1);
      assign hi_node[n] = adr_mid_q[SEL] ? hi_node[2*n+1] : hi_node[2*n];
    end

    assign tree_out[p] = hi_node[1];
  end

  always_ff @(posedge rdclk) begin
    for (int p = 0; p < `FM_NUMRPRT; p++) begin
      rd_dout[p] <= tree_out[p];
    end
  end

  // valid follows the same three registers as the data
  always_ff @(posedge rdclk) begin
    if (rst) begin
      for (int s = 0; s < `FM_RDDLY; s++) begin
        vld_sr[s] <= '0;
      end
    end else begin
      vld_sr[0] <= read;
      for (int s = 1; s < `FM_RDDLY; s++) begin
        vld_sr[s] <= vld_sr[s-1];
      end
    end
  end

  assign rd_vld = vld_sr[`FM_RDDLY-1];

  for (genvar p = 0; p < `FM_NUMRPRT; p++) begin : g_chk
    a_rd_vld_after_read: assert property (
      @(posedge rdclk) disable iff (rst)
      read[p] |-> ##(`FM_RDDLY) rd_vld[p]
    );

    // returned word must be known while valid
    a_rd_dout_known: assert property (
      @(posedge rdclk) disable iff (rst)
      rd_vld[p] |-> !$isunknown(rd_dout[p])
    );
  end

endmodule

`default_nettype wire

// ==== design/flop_mem_top.sv ====
`default_nettype none

`include "flop_mem_cfg.svh"

module flop_mem_top (
  input  wire                       rdclk,
  input  wire                       rst,
  input  wire flop_mem_pkg::wport_t write,
  input  wire flop_mem_pkg::addr_t  wr_adr  [`FM_NUMWPRT],
  input  wire flop_mem_pkg::data_t  din     [`FM_NUMWPRT],
  input  wire flop_mem_pkg::data_t  bw      [`FM_NUMWPRT],
  input  wire flop_mem_pkg::rport_t read,
  input  wire flop_mem_pkg::addr_t  rd_adr  [`FM_NUMRPRT],
  output wire flop_mem_pkg::data_t  rd_dout [`FM_NUMRPRT],
  output wire flop_mem_pkg::rport_t rd_vld,
  output wire [`FM_DEPTH*`FM_WIDTH-1:0] fout
);

  import flop_mem_pkg::*;

  // registered write command
  wire wport_t write_q;
  wire addr_t  wr_adr_q [`FM_NUMWPRT];
  wire data_t  din_q    [`FM_NUMWPRT];
  wire data_t  bw_q     [`FM_NUMWPRT];

  wire data_t mem_words [`FM_DEPTH]; // array contents to the read side

  wr_input_stage u_wr_stage (
    .rdclk    (rdclk),
    .rst      (rst),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .bw       (bw),
    .write_q  (write_q),
    .wr_adr_q (wr_adr_q),
    .din_q    (din_q),
    .bw_q     (bw_q)
  );

  flop_mem_array u_array (
    .rdclk     (rdclk),
    .rst       (rst),
    .write_q   (write_q),
    .wr_adr_q  (wr_adr_q),
    .din_q     (din_q),
    .bw_q      (bw_q),
    .mem_words (mem_words),
    .fout      (fout)
  );

  read_mux_tree u_rd_tree (
    .rdclk     (rdclk),
    .rst       (rst),
    .read      (read),
    .rd_adr    (rd_adr),
    .mem_words (mem_words),
    .rd_dout   (rd_dout),
    .rd_vld    (rd_vld)
  );

endmodule

`default_nettype wire

// ==== verif/flop_mem_tb.sv ====
`default_nettype none

`include "flop_mem_cfg.svh"

module flop_mem_tb;

  import flop_mem_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int N_ENT      = 32; // used entries plus idle tail
  localparam data_t FULL    = '1;

  logic   rdclk;
  logic   rst;
  wport_t write;
  addr_t  wr_adr  [`FM_NUMWPRT];
  data_t  din     [`FM_NUMWPRT];
  data_t  bw      [`FM_NUMWPRT];
  rport_t read;
  addr_t  rd_adr  [`FM_NUMRPRT];
  data_t  rd_dout [`FM_NUMRPRT];
  rport_t rd_vld;
  logic [`FM_DEPTH*`FM_WIDTH-1:0] fout;

  // stimulus table with one entry per cycle
  wport_t t_write [N_ENT];
  addr_t  t_wadr  [N_ENT][`FM_NUMWPRT];
  data_t  t_din   [N_ENT][`FM_NUMWPRT];
  data_t  t_bw    [N_ENT][`FM_NUMWPRT];
  rport_t t_read  [N_ENT];
  addr_t  t_radr  [N_ENT][`FM_NUMRPRT];
  int     n_used;

  data_t shadow [`FM_DEPTH]; // expected array contents
  data_t exp_data [`FM_NUMRPRT][$];
  int    exp_due  [`FM_NUMRPRT][$];

  int cyc;
  int seed = 32'h90cc5809;

  flop_mem_top dut_i (
    .rdclk   (rdclk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld),
    .fout    (fout)
  );

  always #(CLK_PERIOD / 2) rdclk = ~rdclk;

  always @(posedge rdclk) begin
    cyc <= cyc + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    string msg;
    msg = $sformatf("[FAIL] time %0t %s got %0h expected %0h", $time, sig, got, exp);
    abort_run(msg);
  endtask

  function automatic data_t rnd_word();
    return data_t'($random(seed));
  endfunction

  task automatic add_entry(input wport_t w,
                           input addr_t wa0, input data_t d0, input data_t b0,
                           input addr_t wa1, input data_t d1, input data_t b1,
                           input rport_t r, input addr_t ra0, input addr_t ra1);
    if (n_used >= N_ENT) begin
      abort_run("stimulus table is too small for its entries");
    end
    t_write[n_used]   = w;
    t_wadr[n_used][0] = wa0;
    t_din[n_used][0]  = d0;
    t_bw[n_used][0]   = b0;
    t_wadr[n_used][1] = wa1;
    t_din[n_used][1]  = d1;
    t_bw[n_used][1]   = b1;
    t_read[n_used]    = r;
    t_radr[n_used][0] = ra0;
    t_radr[n_used][1] = ra1;
    n_used++;
  endtask

  task automatic build_table();
    for (int i = 0; i < N_ENT; i++) begin
      t_write[i] = '0;
      t_read[i]  = '0;
      for (int p = 0; p < `FM_NUMWPRT; p++) begin
        t_wadr[i][p] = '0;
        t_din[i][p]  = '0;
        t_bw[i][p]   = '0;
      end
      for (int p = 0; p < `FM_NUMRPRT; p++) begin
        t_radr[i][p] = '0;
      end
    end
    n_used = 0;

    // single full-mask writes
    add_entry(2'b01, 5'd0, rnd_word(), FULL, 5'd0, 8'h00, 8'h00,
              2'b00, 5'd0, 5'd0);
    add_entry(2'b01, 5'd3, rnd_word(), FULL, 5'd0, 8'h00, 8'h00,
              2'b00, 5'd0, 5'd0);
    add_entry(2'b10, 5'd0, 8'h00, 8'h00, 5'd7, rnd_word(), FULL,
              2'b00, 5'd0, 5'd0);
    add_entry(2'b01, 5'd31, rnd_word(), FULL, 5'd0, 8'h00, 8'h00,
              2'b00, 5'd0, 5'd0);

    // partial masks over words already written
    add_entry(2'b01, 5'd3, rnd_word(), 8'h0f, 5'd0, 8'h00, 8'h00,
              2'b00, 5'd0, 5'd0);
    add_entry(2'b10, 5'd0, 8'h00, 8'h00, 5'd7, rnd_word(), 8'ha5,
              2'b00, 5'd0, 5'd0);

    // both ports on different words then on the same word
    add_entry(2'b11, 5'd10, rnd_word(), FULL, 5'd20, rnd_word(), FULL,
              2'b00, 5'd0, 5'd0);
    add_entry(2'b11, 5'd5, rnd_word(), FULL, 5'd5, rnd_word(), 8'h3c,
              2'b00, 5'd0, 5'd0);
    add_entry(2'b11, 5'd5, rnd_word(), 8'hf0, 5'd5, rnd_word(), 8'h81,
              2'b00, 5'd0, 5'd0);

    // back to back reads
    add_entry(2'b00, 5'd0, 8'h00, 8'h00, 5'd0, 8'h00, 8'h00,
              2'b11, 5'd0, 5'd3);
    add_entry(2'b00, 5'd0, 8'h00, 8'h00, 5'd0, 8'h00, 8'h00,
              2'b11, 5'd7, 5'd31);
    add_entry(2'b00, 5'd0, 8'h00, 8'h00, 5'd0, 8'h00, 8'h00,
              2'b11, 5'd10, 5'd20);
    add_entry(2'b00, 5'd0, 8'h00, 8'h00, 5'd0, 8'h00, 8'h00,
              2'b01, 5'd5, 5'd0);
    add_entry(2'b00, 5'd0, 8'h00, 8'h00, 5'd0, 8'h00, 8'h00,
              2'b10, 5'd0, 5'd5);

    // read next to a write of the same word
    add_entry(2'b01, 5'd9, rnd_word(), FULL, 5'd0, 8'h00, 8'h00,
              2'b01, 5'd9, 5'd0);
    add_entry(2'b10, 5'd0, 8'h00, 8'h00, 5'd9, rnd_word(), 8'h55,
              2'b11, 5'd9, 5'd9);
    add_entry(2'b00, 5'd0, 8'h00, 8'h00, 5'd0, 8'h00, 8'h00,
              2'b11, 5'd9, 5'd9);

    // mixed random traffic
    for (int k = 0; k < 8; k++) begin
      add_entry(wport_t'($random(seed)), addr_t'($random(seed)), rnd_word(), rnd_word(),
                addr_t'($random(seed)), rnd_word(), rnd_word(),
                rport_t'($random(seed)), addr_t'($random(seed)), addr_t'($random(seed)));
    end
  endtask

  // masked update with the later port last so it wins shared bits
  task automatic apply_writes(input int i);
    addr_t a;
    for (int p = 0; p < `FM_NUMWPRT; p++) begin
      if (t_write[i][p]) begin
        a = t_wadr[i][p];
        shadow[a] = (shadow[a] & ~t_bw[i][p]) | (t_din[i][p] & t_bw[i][p]);
      end
    end
  endtask

  task automatic drive_entry(input int i);
    write = t_write[i];
    read  = t_read[i];
    for (int p = 0; p < `FM_NUMWPRT; p++) begin
      wr_adr[p] = t_wadr[i][p];
      din[p]    = t_din[i][p];
      bw[p]     = t_bw[i][p];
    end
    for (int p = 0; p < `FM_NUMRPRT; p++) begin
      rd_adr[p] = t_radr[i][p];
    end
  endtask

  task automatic queue_reads(input int i);
    for (int p = 0; p < `FM_NUMRPRT; p++) begin
      if (t_read[i][p]) begin
        exp_data[p].push_back(shadow[t_radr[i][p]]);
        exp_due[p].push_back(cyc + `FM_RDDLY);
      end
    end
  endtask

  task automatic check_outputs();
    data_t exp_word;
    int    due;
    for (int p = 0; p < `FM_NUMRPRT; p++) begin
      assert (!$isunknown(rd_vld[p]))
        else abort_run($sformatf("rd_vld[%0d] is unknown at time %0t", p, $time));
      if (rd_vld[p]) begin
        assert (exp_data[p].size() != 0)
          else abort_run($sformatf("rd_vld[%0d] high with no read pending at time %0t",
                                   p, $time));
        exp_word = exp_data[p].pop_front();
        due      = exp_due[p].pop_front();
        assert (cyc == due)
          else report_mismatch($sformatf("rd_vld[%0d] cycle", p), cyc, due);
        assert (rd_dout[p] === exp_word)
          else report_mismatch($sformatf("rd_dout[%0d]", p), rd_dout[p], exp_word);
      end else begin
        assert (exp_due[p].size() == 0 || exp_due[p][0] > cyc)
          else abort_run($sformatf("read on port %0d not returned by its cycle, time %0t",
                                   p, $time));
      end
    end
    for (int a = 0; a < `FM_DEPTH; a++) begin
      assert (fout[a*`FM_WIDTH +: `FM_WIDTH] === shadow[a])
        else report_mismatch($sformatf("fout word %0d", a),
                             fout[a*`FM_WIDTH +: `FM_WIDTH], shadow[a]);
    end
  endtask

  initial begin
    #((N_ENT + 20) * CLK_PERIOD);
    abort_run($sformatf("timeout, run still going after %0d time units",
                        (N_ENT + 20) * CLK_PERIOD));
  end

  initial begin
    rdclk = 1'b0;
    rst   = 1'b1;
    cyc   = 0;
    write = '0;
    read  = '0;
    for (int p = 0; p < `FM_NUMWPRT; p++) begin
      wr_adr[p] = '0;
      din[p]    = '0;
      bw[p]     = '0;
    end
    for (int p = 0; p < `FM_NUMRPRT; p++) begin
      rd_adr[p] = '0;
    end
    for (int a = 0; a < `FM_DEPTH; a++) begin
      shadow[a] = '0;
    end
    build_table();

    repeat (2) @(posedge rdclk);
    @(negedge rdclk);
    rst = 1'b0;

    assert (rd_vld === '0)
      else report_mismatch("rd_vld after reset", rd_vld, 0);
    assert (fout === '0)
      else abort_run("fout is not all zero after reset");

    // writes of entry i-1 reach the array while entry i is sampled
    for (int i = 0; i < N_ENT; i++) begin
      check_outputs();
      if (i > 0) begin
        apply_writes(i - 1);
      end
      drive_entry(i);
      queue_reads(i);
      @(negedge rdclk);
    end

    for (int p = 0; p < `FM_NUMRPRT; p++) begin
      assert (exp_data[p].size() == 0)
        else abort_run($sformatf("port %0d still has reads pending at the end", p));
    end

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/flop_mem_pkg.sv
design/wr_input_stage.sv
flop_mem_array/flop_mem_array.sv
read_mux_tree/read_mux_tree.sv
design/flop_mem_top.sv
verif/flop_mem_tb.sv
